// File: Bender.yml
package:
  name: accel_ctrl

sources:
  - accel_ctrl_pkg.sv
  - accel_cmd_regs.sv
  - accel_status_track.sv
  - accel_csr_read.sv
  - accel_ctrl_top.sv
  - target: simulation
    files:
      - tb_accel_ctrl.sv

// File: accel_cmd_regs.sv
`timescale 1ns/1ns
`default_nettype none

module accel_cmd_regs #(
  parameter int ACCEL_COUNT = 9
) (
  input  wire                             clk,
  input  wire                             rst,

  input  wire                             io_en,
  input  wire                             io_wen,
  input  wire accel_ctrl_pkg::io_strb_t   io_strb,
  input  wire accel_ctrl_pkg::io_addr_t   io_addr,
  input  wire accel_ctrl_pkg::io_data_t   io_wr_data,

  output logic                            cmd_valid,
  output accel_ctrl_pkg::accel_id_t       cmd_accel,
  output accel_ctrl_pkg::dma_len_t        cmd_len,
  output accel_ctrl_pkg::pmem_addr_t      cmd_addr,
  output accel_ctrl_pkg::sme_state_t      cmd_state,

  output logic [ACCEL_COUNT-1:0]          cmd_init,
  output logic [ACCEL_COUNT-1:0]          cmd_stop,
  output logic [ACCEL_COUNT-1:0]          release_index,
  output logic [ACCEL_COUNT-1:0]          active_mask
);

  accel_ctrl_pkg::accel_id_t wr_id;
  accel_ctrl_pkg::reg_off_t  wr_off;
  logic [ACCEL_COUNT-1:0]    id_onehot;
  logic                      wr_en;
  logic                      agg_wr;
  logic                      acc_wr;
  logic                      ctrl_wr;
  logic                      release_wr;
  logic                      mask_wr;

  assign wr_id  = accel_ctrl_pkg::addr_accel_id(io_addr);
  assign wr_off = accel_ctrl_pkg::addr_reg_off(io_addr);

  // the ip-check window no longer exists, so writes there are dropped
  assign wr_en  = io_en && io_wen && !io_addr[accel_ctrl_pkg::IPCHK_SEL_BIT];
  assign agg_wr = wr_en && io_addr[accel_ctrl_pkg::AGG_SEL_BIT];
  assign acc_wr = wr_en && !io_addr[accel_ctrl_pkg::AGG_SEL_BIT];

  // one bit per existing accelerator, all zero for an unused window
  always_comb begin
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      id_onehot[i] = (wr_id == accel_ctrl_pkg::accel_id_t'(i));
    end
  end

  // command pulses only look at byte lane 0
  assign ctrl_wr    = acc_wr && (wr_off == accel_ctrl_pkg::OFF_CTRL) && io_strb[0] &&
                      (|id_onehot);
  assign release_wr = acc_wr && (wr_off == accel_ctrl_pkg::OFF_RELEASE) && (|id_onehot);
  assign mask_wr    = agg_wr && (wr_off == accel_ctrl_pkg::OFF_ACTIVE_MASK);

  // pulses and mask
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid     <= 1'b0;
      cmd_init      <= '0;
      cmd_stop      <= '0;
      release_index <= '0;
      active_mask   <= '0;
    end else begin
      cmd_valid     <= 1'b0;
      cmd_init      <= '0;
      cmd_stop      <= '0;
      release_index <= '0;
      if (ctrl_wr) begin
        cmd_valid <= io_wr_data[accel_ctrl_pkg::CTRL_START_BIT];
        cmd_init  <= id_onehot & {ACCEL_COUNT{io_wr_data[accel_ctrl_pkg::CTRL_START_BIT]}};
        cmd_stop  <= id_onehot & {ACCEL_COUNT{io_wr_data[accel_ctrl_pkg::CTRL_STOP_BIT]}};
      end
      if (release_wr) begin
        release_index <= id_onehot & {ACCEL_COUNT{io_wr_data[accel_ctrl_pkg::RELEASE_BIT]}};
      end
      if (mask_wr) begin
        active_mask <= io_wr_data[ACCEL_COUNT-1:0];
      end
    end
  end

  // shared command registers, one copy written through any window
  always_ff @(posedge clk) begin
    if (ctrl_wr) begin
      cmd_accel <= wr_id;
    end
    if (acc_wr) begin
      case (wr_off)
        accel_ctrl_pkg::OFF_LEN:      cmd_len <= accel_ctrl_pkg::dma_len_t'(io_wr_data);
        accel_ctrl_pkg::OFF_ADDR:     cmd_addr <= accel_ctrl_pkg::pmem_addr_t'(io_wr_data);
        accel_ctrl_pkg::OFF_STATE_LO: cmd_state[31:0] <= io_wr_data;
        accel_ctrl_pkg::OFF_STATE_HI: cmd_state[63:32] <= io_wr_data;
        default: ;
      endcase
    end
  end

  // a single write never targets more than one accelerator
  a_pulse_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(cmd_init) && $onehot0(cmd_stop) && $onehot0(release_index));

  // the start descriptor and the reload of the same engine go out together
  a_valid_has_init: assert property (@(posedge clk) disable iff (rst)
    cmd_valid |-> cmd_init[cmd_accel]);

endmodule

`default_nettype wire

// File: accel_csr_read.sv
`timescale 1ns/1ns
`default_nettype none

module accel_csr_read #(
  parameter int ACCEL_COUNT = 9
) (
  input  wire                             clk,
  input  wire                             rst,

  input  wire                             io_en,
  input  wire                             io_wen,
  input  wire accel_ctrl_pkg::io_addr_t   io_addr,

  input  wire accel_ctrl_pkg::dma_len_t   cmd_len,
  input  wire accel_ctrl_pkg::pmem_addr_t cmd_addr,
  input  wire accel_ctrl_pkg::sme_state_t cmd_state,
  input  wire  [ACCEL_COUNT-1:0]          active_mask,

  input  wire  [ACCEL_COUNT-1:0]          status_done,
  input  wire  [ACCEL_COUNT-1:0]          status_match,
  input  wire  [ACCEL_COUNT-1:0]          status_error,
  input  wire  [ACCEL_COUNT-1:0]          done_err,
  input  wire  [ACCEL_COUNT-1:0]          masked_done,
  input  wire accel_ctrl_pkg::accel_id_t  next_done,

  input  wire  [ACCEL_COUNT-1:0]          accel_busy,
  input  wire  [ACCEL_COUNT-1:0]          match_valid,
  input  wire  [ACCEL_COUNT-1:0]          match_error,
  input  wire  [ACCEL_COUNT-1:0]          desc_error,

  output accel_ctrl_pkg::io_data_t        io_rd_data,
  output logic                            io_rd_valid
);

  accel_ctrl_pkg::accel_id_t rd_id;
  accel_ctrl_pkg::reg_off_t  rd_off;
  accel_ctrl_pkg::io_data_t  rd_word;
  logic                      rd_en;
  logic                      rd_id_ok;

  assign rd_en    = io_en && !io_wen;
  assign rd_id    = accel_ctrl_pkg::addr_accel_id(io_addr);
  assign rd_off   = accel_ctrl_pkg::addr_reg_off(io_addr);
  assign rd_id_ok = (rd_id < ACCEL_COUNT);

  always_comb begin
    rd_word = '0;
    if (io_addr[accel_ctrl_pkg::IPCHK_SEL_BIT]) begin
      // nothing lives in the ip-check window any more
      rd_word = '0;
    end else if (io_addr[accel_ctrl_pkg::AGG_SEL_BIT]) begin
      case (rd_off)
        accel_ctrl_pkg::OFF_DONE_OR_MATCH:
          rd_word = accel_ctrl_pkg::io_data_t'(status_done | status_match);
        accel_ctrl_pkg::OFF_DONE:        rd_word = accel_ctrl_pkg::io_data_t'(status_done);
        accel_ctrl_pkg::OFF_MATCH:       rd_word = accel_ctrl_pkg::io_data_t'(status_match);
        accel_ctrl_pkg::OFF_BUSY:        rd_word = accel_ctrl_pkg::io_data_t'(accel_busy);
        accel_ctrl_pkg::OFF_DESC_ERR:    rd_word = accel_ctrl_pkg::io_data_t'(desc_error);
        accel_ctrl_pkg::OFF_DONE_ERR:    rd_word = accel_ctrl_pkg::io_data_t'(done_err);
        accel_ctrl_pkg::OFF_ACTIVE_MASK: rd_word = accel_ctrl_pkg::io_data_t'(active_mask);
        accel_ctrl_pkg::OFF_MASKED_DONE: rd_word = accel_ctrl_pkg::io_data_t'(masked_done);
        accel_ctrl_pkg::OFF_NEXT_DONE:   rd_word = accel_ctrl_pkg::io_data_t'(next_done);
        accel_ctrl_pkg::OFF_STATUS_ERR:  rd_word = accel_ctrl_pkg::io_data_t'(status_error);
        default:                         rd_word = '0;
      endcase
    end else begin
      case (rd_off)
        accel_ctrl_pkg::OFF_CTRL: begin
          // status word of one engine, zero for an unused window
          if (rd_id_ok) begin
            rd_word[accel_ctrl_pkg::ST_BUSY_BIT]        = accel_busy[rd_id];
            rd_word[accel_ctrl_pkg::ST_DONE_BIT]        = status_done[rd_id];
            rd_word[accel_ctrl_pkg::ST_MATCH_BIT]       = status_match[rd_id];
            rd_word[accel_ctrl_pkg::ST_ERROR_BIT]       = status_error[rd_id];
            rd_word[accel_ctrl_pkg::ST_MATCH_VALID_BIT] = match_valid[rd_id];
            rd_word[accel_ctrl_pkg::ST_MATCH_ERROR_BIT] = match_error[rd_id];
          end
        end
        accel_ctrl_pkg::OFF_LEN:      rd_word = accel_ctrl_pkg::io_data_t'(cmd_len);
        accel_ctrl_pkg::OFF_ADDR:     rd_word = accel_ctrl_pkg::io_data_t'(cmd_addr);
        accel_ctrl_pkg::OFF_STATE_LO: rd_word = cmd_state[31:0];
        accel_ctrl_pkg::OFF_STATE_HI: rd_word = cmd_state[63:32];
        default:                      rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
    end else begin
      io_rd_valid <= rd_en;
    end
  end

  // data only moves on a read, it holds between reads
  always_ff @(posedge clk) begin
    if (rd_en) begin
      io_rd_data <= rd_word;
    end
  end

  a_rd_valid_follows: assert property (@(posedge clk) disable iff (rst)
    rd_en |=> io_rd_valid);

  a_rd_valid_only: assert property (@(posedge clk) disable iff (rst)
    !rd_en |=> !io_rd_valid);

endmodule

`default_nettype wire

// File: accel_ctrl.f
accel_ctrl_pkg.sv
accel_cmd_regs.sv
accel_status_track.sv
accel_csr_read.sv
accel_ctrl_top.sv
tb_accel_ctrl.sv

// File: accel_ctrl_pkg.sv
`default_nettype none

package accel_ctrl_pkg;

  // host port fields
  typedef logic [31:0] io_data_t;
  typedef logic [3:0]  io_strb_t;
  typedef logic [21:0] io_addr_t;

  // accelerator number and word offset inside its window
  typedef logic [3:0]  accel_id_t;
  typedef logic [5:0]  reg_off_t;

  // shared command fields
  typedef logic [13:0] dma_len_t;
  typedef logic [7:0]  pmem_addr_t;
  typedef logic [63:0] sme_state_t;

  // window select bits of io_addr
  localparam int AGG_SEL_BIT   = 10;
  localparam int IPCHK_SEL_BIT = 11;

  // per-accelerator map
  localparam reg_off_t OFF_CTRL     = 6'h00;
  localparam reg_off_t OFF_LEN      = 6'h04;
  localparam reg_off_t OFF_ADDR     = 6'h08;
  localparam reg_off_t OFF_STATE_LO = 6'h10;
  localparam reg_off_t OFF_STATE_HI = 6'h14;
  localparam reg_off_t OFF_RELEASE  = 6'h28;

  // aggregate map
  localparam reg_off_t OFF_DONE_OR_MATCH = 6'h00;
  localparam reg_off_t OFF_DONE          = 6'h04;
  localparam reg_off_t OFF_MATCH         = 6'h08;
  localparam reg_off_t OFF_BUSY          = 6'h0C;
  localparam reg_off_t OFF_DESC_ERR      = 6'h10;
  localparam reg_off_t OFF_DONE_ERR      = 6'h14;
  localparam reg_off_t OFF_ACTIVE_MASK   = 6'h18;
  localparam reg_off_t OFF_MASKED_DONE   = 6'h1C;
  localparam reg_off_t OFF_NEXT_DONE     = 6'h20;
  localparam reg_off_t OFF_STATUS_ERR    = 6'h24;

  // control word bits
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_STOP_BIT  = 4;
  localparam int RELEASE_BIT    = 0;

  // per-accelerator status word layout
  localparam int ST_BUSY_BIT        = 1;
  localparam int ST_DONE_BIT        = 8;
  localparam int ST_MATCH_BIT       = 9;
  localparam int ST_ERROR_BIT       = 10;
  localparam int ST_MATCH_VALID_BIT = 16;
  localparam int ST_MATCH_ERROR_BIT = 17;

  // accelerator number sits in address bits 9..6
  function automatic accel_id_t addr_accel_id(io_addr_t addr);
    return addr[9:6];
  endfunction

  // word offset, byte lanes forced to zero
  function automatic reg_off_t addr_reg_off(io_addr_t addr);
    return {addr[5:2], 2'b00};
  endfunction

endpackage

`default_nettype wire

// File: accel_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module accel_ctrl_top #(
  parameter int ACCEL_COUNT = 9
) (
  input  wire                             clk,
  input  wire                             rst,

  // host port
  input  wire                             io_en,
  input  wire                             io_wen,
  input  wire accel_ctrl_pkg::io_strb_t   io_strb,
  input  wire accel_ctrl_pkg::io_addr_t   io_addr,
  input  wire accel_ctrl_pkg::io_data_t   io_wr_data,
  output wire accel_ctrl_pkg::io_data_t   io_rd_data,
  output wire                             io_rd_valid,

  // towards the dma engine and the accelerators
  output wire                             cmd_valid,
  output wire accel_ctrl_pkg::accel_id_t  cmd_accel,
  output wire accel_ctrl_pkg::dma_len_t   cmd_len,
  output wire accel_ctrl_pkg::pmem_addr_t cmd_addr,
  output wire accel_ctrl_pkg::sme_state_t cmd_state,
  output wire  [ACCEL_COUNT-1:0]          cmd_init,
  output wire  [ACCEL_COUNT-1:0]          cmd_stop,
  output wire  [ACCEL_COUNT-1:0]          release_index,

  // from the accelerators
  input  wire  [ACCEL_COUNT-1:0]          accel_busy,
  input  wire  [ACCEL_COUNT-1:0]          accel_last,
  input  wire  [ACCEL_COUNT-1:0]          sme_match,
  input  wire  [ACCEL_COUNT-1:0]          sme_error,
  input  wire  [ACCEL_COUNT-1:0]          match_valid,
  input  wire  [ACCEL_COUNT-1:0]          match_error,
  input  wire  [ACCEL_COUNT-1:0]          desc_error
);

  wire [ACCEL_COUNT-1:0]          active_mask;
  wire [ACCEL_COUNT-1:0]          status_done;
  wire [ACCEL_COUNT-1:0]          status_match;
  wire [ACCEL_COUNT-1:0]          status_error;
  wire [ACCEL_COUNT-1:0]          done_err;
  wire [ACCEL_COUNT-1:0]          masked_done;
  wire accel_ctrl_pkg::accel_id_t next_done;

  accel_cmd_regs #(
    .ACCEL_COUNT(ACCEL_COUNT)
  ) i_accel_cmd_regs (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_strb      (io_strb),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .cmd_valid    (cmd_valid),
    .cmd_accel    (cmd_accel),
    .cmd_len      (cmd_len),
    .cmd_addr     (cmd_addr),
    .cmd_state    (cmd_state),
    .cmd_init     (cmd_init),
    .cmd_stop     (cmd_stop),
    .release_index(release_index),
    .active_mask  (active_mask)
  );

  accel_status_track #(
    .ACCEL_COUNT(ACCEL_COUNT)
  ) i_accel_status_track (
    .clk         (clk),
    .rst         (rst),
    .cmd_init    (cmd_init),
    .cmd_stop    (cmd_stop),
    .active_mask (active_mask),
    .accel_busy  (accel_busy),
    .accel_last  (accel_last),
    .sme_match   (sme_match),
    .sme_error   (sme_error),
    .status_done (status_done),
    .status_match(status_match),
    .status_error(status_error),
    .done_err    (done_err),
    .masked_done (masked_done),
    .next_done   (next_done)
  );

  accel_csr_read #(
    .ACCEL_COUNT(ACCEL_COUNT)
  ) i_accel_csr_read (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .cmd_len     (cmd_len),
    .cmd_addr    (cmd_addr),
    .cmd_state   (cmd_state),
    .active_mask (active_mask),
    .status_done (status_done),
    .status_match(status_match),
    .status_error(status_error),
    .done_err    (done_err),
    .masked_done (masked_done),
    .next_done   (next_done),
    .accel_busy  (accel_busy),
    .match_valid (match_valid),
    .match_error (match_error),
    .desc_error  (desc_error),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid)
  );

endmodule

`default_nettype wire

// File: accel_status_track.sv
`timescale 1ns/1ns
`default_nettype none

module accel_status_track #(
  parameter int ACCEL_COUNT = 9
) (
  input  wire                             clk,
  input  wire                             rst,

  input  wire  [ACCEL_COUNT-1:0]          cmd_init,
  input  wire  [ACCEL_COUNT-1:0]          cmd_stop,
  input  wire  [ACCEL_COUNT-1:0]          active_mask,

  input  wire  [ACCEL_COUNT-1:0]          accel_busy,
  input  wire  [ACCEL_COUNT-1:0]          accel_last,
  input  wire  [ACCEL_COUNT-1:0]          sme_match,
  input  wire  [ACCEL_COUNT-1:0]          sme_error,

  output logic [ACCEL_COUNT-1:0]          status_done,
  output logic [ACCEL_COUNT-1:0]          status_match,
  output logic [ACCEL_COUNT-1:0]          status_error,
  output logic [ACCEL_COUNT-1:0]          done_err,
  output logic [ACCEL_COUNT-1:0]          masked_done,
  output accel_ctrl_pkg::accel_id_t       next_done
);

  logic [ACCEL_COUNT-1:0] done_seen;

  // end of stream either from the flag or from this cycle's pulse
  assign done_seen = status_done | accel_last;

  // sticky flags, init clears and wins over a same-cycle set
  always_ff @(posedge clk) begin
    if (rst) begin
      status_done  <= '0;
      status_match <= '0;
      status_error <= '0;
    end else begin
      status_done  <= (status_done | accel_last | cmd_stop) & ~cmd_init;
      status_match <= (status_match | sme_match) & ~cmd_init;
      status_error <= (status_error | sme_error) & ~cmd_init;
    end
  end

  // done reported while the engine still says busy
  // only reset clears it, init leaves it alone
  always_ff @(posedge clk) begin
    if (rst) begin
      done_err <= '0;
    end else begin
      done_err <= done_err | (done_seen & accel_busy);
    end
  end

  assign masked_done = status_done & active_mask;

  // lowest index wins, so scan downwards and let later hits override
  always_comb begin
    next_done = '0;
    for (int i = ACCEL_COUNT - 1; i >= 0; i--) begin
      if (masked_done[i]) begin
        next_done = accel_ctrl_pkg::accel_id_t'(i);
      end
    end
  end

  a_next_done_set: assert property (@(posedge clk) disable iff (rst)
    (masked_done != '0) |-> masked_done[next_done]);

endmodule

`default_nettype wire

// File: tb_accel_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_accel_ctrl;

  localparam int N = 9;
  localparam int MAX_ROWS = 96;
  localparam int OP_WR = 0;
  localparam int OP_RD = 1;
  localparam int OP_DRV = 2;
  // accelerator input groups used by drive rows
  localparam int IN_LAST = 0;
  localparam int IN_MATCH = 1;
  localparam int IN_ERROR = 2;
  localparam int IN_BUSY = 3;
  localparam int IN_MVALID = 4;
  localparam int IN_MERR = 5;
  localparam int IN_DESC = 6;

  logic clk = 1'b0;
  logic rst;
  logic io_en;
  logic io_wen;
  logic [3:0] io_strb;
  logic [21:0] io_addr;
  logic [31:0] io_wr_data;
  logic [31:0] io_rd_data;
  logic io_rd_valid;
  logic cmd_valid;
  logic [3:0] cmd_accel;
  logic [13:0] cmd_len;
  logic [7:0] cmd_addr;
  logic [63:0] cmd_state;
  logic [N-1:0] cmd_init;
  logic [N-1:0] cmd_stop;
  logic [N-1:0] release_index;
  logic [N-1:0] accel_busy;
  logic [N-1:0] accel_last;
  logic [N-1:0] sme_match;
  logic [N-1:0] sme_error;
  logic [N-1:0] match_valid;
  logic [N-1:0] match_error;
  logic [N-1:0] desc_error;

  // stimulus table
  int row_op [MAX_ROWS];
  int row_test [MAX_ROWS];
  logic [21:0] row_addr [MAX_ROWS];
  logic [31:0] row_data [MAX_ROWS];
  logic [31:0] row_exp [MAX_ROWS];
  // held command registers expected after each row
  logic [13:0] row_len [MAX_ROWS];
  logic [7:0] row_paddr [MAX_ROWS];
  logic [63:0] row_state [MAX_ROWS];
  int n_rows = 0;
  int cur_test = 0;
  int cur_row = 0;
  logic table_ready = 1'b0;
  int n_checks = 0;
  int n_errors = 0;
  int test_errs = 0;

  // expected state of the register block while the table is built
  logic [13:0] m_len;
  logic [7:0] m_addr;
  logic [63:0] m_state;
  logic [N-1:0] m_mask = '0;
  logic [N-1:0] m_done = '0;
  logic [N-1:0] m_match = '0;
  logic [N-1:0] m_err = '0;
  logic [N-1:0] m_derr = '0;
  logic [N-1:0] m_busy = '0;
  logic [N-1:0] m_mvalid = '0;
  logic [N-1:0] m_merr = '0;
  logic [N-1:0] m_desc = '0;

  accel_ctrl_top #(
    .ACCEL_COUNT(N)
  ) i_accel_ctrl_top (
    .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb),
    .io_addr(io_addr), .io_wr_data(io_wr_data), .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid), .cmd_valid(cmd_valid), .cmd_accel(cmd_accel),
    .cmd_len(cmd_len), .cmd_addr(cmd_addr), .cmd_state(cmd_state), .cmd_init(cmd_init),
    .cmd_stop(cmd_stop), .release_index(release_index), .accel_busy(accel_busy),
    .accel_last(accel_last), .sme_match(sme_match), .sme_error(sme_error),
    .match_valid(match_valid), .match_error(match_error), .desc_error(desc_error)
  );

  always #10 clk = ~clk;

  function automatic logic [21:0] acc_addr(input int id, input logic [5:0] off);
    return (22'(id) << 6) | 22'(off);
  endfunction

  function automatic logic [21:0] agg_addr(input logic [5:0] off);
    return (22'd1 << 10) | 22'(off);
  endfunction

  function automatic logic [3:0] lowest_set(input logic [N-1:0] v);
    logic found;
    logic [3:0] idx;
    found = 1'b0;
    idx = 4'd0;
    for (int i = 0; i < N; i++) begin
      if (v[i] && !found) begin
        idx = 4'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  function automatic logic [31:0] model_read(input logic [21:0] a);
    logic [5:0] off;
    int id;
    logic [31:0] w;
    off = {a[5:2], 2'b00};
    id = int'(a[9:6]);
    w = '0;
    if (a[11]) begin
      w = '0;
    end else if (a[10]) begin
      case (off)
        accel_ctrl_pkg::OFF_DONE_OR_MATCH: w = 32'(m_done | m_match);
        accel_ctrl_pkg::OFF_DONE:          w = 32'(m_done);
        accel_ctrl_pkg::OFF_MATCH:         w = 32'(m_match);
        accel_ctrl_pkg::OFF_BUSY:          w = 32'(m_busy);
        accel_ctrl_pkg::OFF_DESC_ERR:      w = 32'(m_desc);
        accel_ctrl_pkg::OFF_DONE_ERR:      w = 32'(m_derr);
        accel_ctrl_pkg::OFF_ACTIVE_MASK:   w = 32'(m_mask);
        accel_ctrl_pkg::OFF_MASKED_DONE:   w = 32'(m_done & m_mask);
        accel_ctrl_pkg::OFF_NEXT_DONE:     w = 32'(lowest_set(m_done & m_mask));
        accel_ctrl_pkg::OFF_STATUS_ERR:    w = 32'(m_err);
        default: w = '0;
      endcase
    end else begin
      case (off)
        accel_ctrl_pkg::OFF_CTRL: begin
          if (id < N) begin
            w = {14'd0, m_merr[id], m_mvalid[id], 5'd0, m_err[id], m_match[id], m_done[id],
                 6'd0, m_busy[id], 1'b0};
          end
        end
        accel_ctrl_pkg::OFF_LEN:      w = 32'(m_len);
        accel_ctrl_pkg::OFF_ADDR:     w = 32'(m_addr);
        accel_ctrl_pkg::OFF_STATE_LO: w = m_state[31:0];
        accel_ctrl_pkg::OFF_STATE_HI: w = m_state[63:32];
        default: w = '0;
      endcase
    end
    return w;
  endfunction

  task automatic add_row(input int op, input logic [21:0] a, input logic [31:0] d,
                         input logic [31:0] e);
    row_op[n_rows] = op;
    row_addr[n_rows] = a;
    row_data[n_rows] = d;
    row_exp[n_rows] = e;
    row_len[n_rows] = m_len;
    row_paddr[n_rows] = m_addr;
    row_state[n_rows] = m_state;
    row_test[n_rows] = cur_test;
    n_rows++;
  endtask

  // expected pulses packed as {accel, valid, release, stop, init}
  task automatic wr(input logic [21:0] a, input logic [31:0] d);
    logic [5:0] off;
    int id;
    logic [N-1:0] init;
    logic [N-1:0] stop;
    logic [N-1:0] rel;
    logic valid;
    off = {a[5:2], 2'b00};
    id = int'(a[9:6]);
    init = '0;
    stop = '0;
    rel = '0;
    valid = 1'b0;
    if (!a[11] && a[10]) begin
      if (off == accel_ctrl_pkg::OFF_ACTIVE_MASK) m_mask = d[N-1:0];
    end else if (!a[11]) begin
      case (off)
        accel_ctrl_pkg::OFF_CTRL: begin
          if (id < N) begin
            valid = d[0];
            init[id] = d[0];
            stop[id] = d[4];
          end
        end
        accel_ctrl_pkg::OFF_LEN:      m_len = d[13:0];
        accel_ctrl_pkg::OFF_ADDR:     m_addr = d[7:0];
        accel_ctrl_pkg::OFF_STATE_LO: m_state[31:0] = d;
        accel_ctrl_pkg::OFF_STATE_HI: m_state[63:32] = d;
        accel_ctrl_pkg::OFF_RELEASE:  if (id < N) rel[id] = d[0];
        default: ;
      endcase
    end
    // init clears done, match and error and beats a same-cycle stop
    m_done = (m_done | stop) & ~init;
    m_match = m_match & ~init;
    m_err = m_err & ~init;
    m_derr = m_derr | (m_done & m_busy);
    add_row(OP_WR, a, d, {valid ? a[9:6] : 4'h0, valid, rel, stop, init});
  endtask

  task automatic rd(input logic [21:0] a);
    add_row(OP_RD, a, 32'h0, model_read(a));
  endtask

  task automatic drv(input int sel, input logic [N-1:0] mask);
    case (sel)
      IN_LAST: begin
        m_derr = m_derr | ((m_done | mask) & m_busy);
        m_done = m_done | mask;
      end
      IN_MATCH:  m_match = m_match | mask;
      IN_ERROR:  m_err = m_err | mask;
      IN_BUSY:   m_busy = mask;
      IN_MVALID: m_mvalid = mask;
      IN_MERR:   m_merr = mask;
      IN_DESC:   m_desc = mask;
      default: ;
    endcase
    m_derr = m_derr | (m_done & m_busy);
    add_row(OP_DRV, 22'(sel), 32'(mask), 32'h0);
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      $display("Error: %s expected %h, got %h (row %0d)", name, exp, act, cur_row);
      n_errors++;
      test_errs++;
    end
  endtask

  task automatic check_pulses(input logic [31:0] e);
    compare("cmd_valid", 32'(e[27]), 32'(cmd_valid));
    if (e[27]) compare("cmd_accel", 32'(e[31:28]), 32'(cmd_accel));
    compare("cmd_init", 32'(e[8:0]), 32'(cmd_init));
    compare("cmd_stop", 32'(e[17:9]), 32'(cmd_stop));
    compare("release_index", 32'(e[26:18]), 32'(release_index));
  endtask

  // levels on the command outputs after a write
  task automatic check_held_regs(input int r);
    compare("cmd_len", 32'(row_len[r]), 32'(cmd_len));
    compare("cmd_addr", 32'(row_paddr[r]), 32'(cmd_addr));
    compare("cmd_state[31:0]", row_state[r][31:0], cmd_state[31:0]);
    compare("cmd_state[63:32]", row_state[r][63:32], cmd_state[63:32]);
  endtask

  task automatic apply_row(input int r);
    cur_row = r;
    case (row_op[r])
      OP_WR: begin
        io_en = 1'b1;
        io_wen = 1'b1;
        io_strb = 4'hf;
        io_addr = row_addr[r];
        io_wr_data = row_data[r];
        @(negedge clk);
        io_en = 1'b0;
        io_wen = 1'b0;
        check_pulses(row_exp[r]);
        check_held_regs(r);
        // every pulse is gone one cycle later
        @(negedge clk);
        check_pulses(32'h0);
      end
      OP_RD: begin
        io_en = 1'b1;
        io_wen = 1'b0;
        io_addr = row_addr[r];
        @(negedge clk);
        io_en = 1'b0;
        n_checks++;
        if (io_rd_valid !== 1'b1) begin
          $display("row %0d: read of address %h returned no io_rd_valid", r, row_addr[r]);
          n_errors++;
          test_errs++;
        end else begin
          compare("io_rd_data", row_exp[r], io_rd_data);
        end
        @(negedge clk);
        n_checks++;
        if (io_rd_valid !== 1'b0) begin
          $display("row %0d: io_rd_valid stayed high for a second cycle", r);
          n_errors++;
          test_errs++;
        end
      end
      default: begin
        case (int'(row_addr[r]))
          IN_LAST:   accel_last = row_data[r][N-1:0];
          IN_MATCH:  sme_match = row_data[r][N-1:0];
          IN_ERROR:  sme_error = row_data[r][N-1:0];
          IN_BUSY:   accel_busy = row_data[r][N-1:0];
          IN_MVALID: match_valid = row_data[r][N-1:0];
          IN_MERR:   match_error = row_data[r][N-1:0];
          default:   desc_error = row_data[r][N-1:0];
        endcase
        @(negedge clk);
        accel_last = '0;
        sme_match = '0;
        sme_error = '0;
      end
    endcase
  endtask

  function automatic string test_title(input int t);
    case (t)
      1: return "command register round trip";
      2: return "start, stop and release pulses";
      3: return "sticky flags and init clear";
      4: return "done while busy";
      5: return "active mask and next done";
      default: return "per-accelerator status word";
    endcase
  endfunction

  task automatic build_table();
    cur_test = 1;
    wr(acc_addr(2, accel_ctrl_pkg::OFF_LEN), $urandom());
    rd(acc_addr(2, accel_ctrl_pkg::OFF_LEN));
    wr(acc_addr(6, accel_ctrl_pkg::OFF_ADDR), $urandom());
    rd(acc_addr(0, accel_ctrl_pkg::OFF_ADDR));
    wr(acc_addr(1, accel_ctrl_pkg::OFF_STATE_LO), $urandom());
    wr(acc_addr(1, accel_ctrl_pkg::OFF_STATE_HI), $urandom());
    rd(acc_addr(1, accel_ctrl_pkg::OFF_STATE_LO));
    rd(acc_addr(8, accel_ctrl_pkg::OFF_STATE_HI));
    // the ip-check window ignores writes and reads zero
    wr((22'd1 << 11) | 22'h04, $urandom());
    rd((22'd1 << 11) | 22'h04);
    rd(acc_addr(2, accel_ctrl_pkg::OFF_LEN));
    cur_test = 2;
    wr(acc_addr(3, accel_ctrl_pkg::OFF_CTRL), 32'h1);
    wr(acc_addr(5, accel_ctrl_pkg::OFF_CTRL), 32'h10);
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE));
    wr(acc_addr(7, accel_ctrl_pkg::OFF_RELEASE), 32'h1);
    wr(acc_addr(12, accel_ctrl_pkg::OFF_CTRL), 32'h11);
    cur_test = 3;
    drv(IN_LAST, 9'h003);
    drv(IN_MATCH, 9'h012);
    drv(IN_ERROR, 9'h102);
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE));
    rd(agg_addr(accel_ctrl_pkg::OFF_MATCH));
    rd(agg_addr(accel_ctrl_pkg::OFF_STATUS_ERR));
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE_OR_MATCH));
    wr(acc_addr(1, accel_ctrl_pkg::OFF_CTRL), 32'h1);
    wr(acc_addr(4, accel_ctrl_pkg::OFF_CTRL), 32'h11);
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE));
    rd(agg_addr(accel_ctrl_pkg::OFF_MATCH));
    rd(agg_addr(accel_ctrl_pkg::OFF_STATUS_ERR));
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE_OR_MATCH));
    cur_test = 4;
    drv(IN_BUSY, 9'h004);
    drv(IN_LAST, 9'h004);
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE_ERR));
    drv(IN_BUSY, 9'h000);
    wr(acc_addr(2, accel_ctrl_pkg::OFF_CTRL), 32'h1);
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE_ERR));
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE));
    cur_test = 5;
    wr(agg_addr(accel_ctrl_pkg::OFF_ACTIVE_MASK), $urandom());
    rd(agg_addr(accel_ctrl_pkg::OFF_ACTIVE_MASK));
    rd(agg_addr(accel_ctrl_pkg::OFF_MASKED_DONE));
    rd(agg_addr(accel_ctrl_pkg::OFF_NEXT_DONE));
    wr(agg_addr(accel_ctrl_pkg::OFF_ACTIVE_MASK), 32'h0);
    rd(agg_addr(accel_ctrl_pkg::OFF_NEXT_DONE));
    wr(agg_addr(accel_ctrl_pkg::OFF_ACTIVE_MASK), 32'h1f0);
    rd(agg_addr(accel_ctrl_pkg::OFF_MASKED_DONE));
    rd(agg_addr(accel_ctrl_pkg::OFF_NEXT_DONE));
    rd(agg_addr(6'h2c));
    cur_test = 6;
    drv(IN_BUSY, 9'h021);
    drv(IN_MVALID, 9'h0a0);
    drv(IN_MERR, 9'h101);
    drv(IN_DESC, 9'h0f0);
    rd(acc_addr(0, accel_ctrl_pkg::OFF_CTRL));
    rd(acc_addr(5, accel_ctrl_pkg::OFF_CTRL));
    rd(acc_addr(7, accel_ctrl_pkg::OFF_CTRL));
    rd(acc_addr(8, accel_ctrl_pkg::OFF_CTRL));
    rd(acc_addr(12, accel_ctrl_pkg::OFF_CTRL));
    rd(agg_addr(accel_ctrl_pkg::OFF_BUSY));
    rd(agg_addr(accel_ctrl_pkg::OFF_DESC_ERR));
    rd(agg_addr(accel_ctrl_pkg::OFF_DONE_ERR));
  endtask

  initial begin
    void'($urandom(85621));
    rst = 1'b1;
    io_en = 1'b0;
    io_wen = 1'b0;
    io_strb = '0;
    io_addr = '0;
    io_wr_data = '0;
    accel_busy = '0;
    accel_last = '0;
    sme_match = '0;
    sme_error = '0;
    match_valid = '0;
    match_error = '0;
    desc_error = '0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      apply_row(r);
      if (r == n_rows - 1 || row_test[r + 1] != row_test[r]) begin
        $display("test %0d, %s: %s, %0d errors", row_test[r], test_title(row_test[r]),
                 (test_errs == 0) ? "ok" : "FAILED", test_errs);
        test_errs = 0;
      end
    end
    $display("%0d rows, %0d checks, %0d errors", n_rows, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // four cycles per row plus the reset time
  initial begin
    int limit_cycles;
    wait (table_ready == 1'b1);
    limit_cycles = n_rows * 4 + 16;
    #(limit_cycles * 20);
    $display("watchdog: run did not finish within %0d cycles", limit_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
